// File: Makefile
# Verilator flow for the RV32I execute slice

VERILATOR ?= verilator
TOP       ?= tb_rv_exec
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation passes only if the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test OK" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rv_exec_trace.txt
// inst pc kind rd data rs2, kind 0 = no output, 1 = write-back, 2 = memory request
// data is the write-back value or the load address, rs2 is compared for loads only
00500093 80000000 1 01 00000005 00000000
ffd00113 80000004 1 02 fffffffd 00000000
002081b3 80000008 1 03 00000002 00000000
40208233 8000000c 1 04 00000008 00000000
0020c2b3 80000010 1 05 fffffff8 00000000
0020e333 80000014 1 06 fffffffd 00000000
0020f3b3 80000018 1 07 00000005 00000000
00112433 8000001c 1 08 00000001 00000000
001134b3 80000020 1 09 00000000 00000000
00112513 80000024 1 0a 00000001 00000000
fff0b593 80000028 1 0b 00000001 00000000
00509633 8000002c 1 0c 05000000 00000000
001156b3 80000030 1 0d 07ffffff 00000000
40115733 80000034 1 0e ffffffff 00000000
4022d793 80000038 1 0f fffffffe 00000000
0022d813 8000003c 1 10 3ffffffe 00000000
00409893 80000040 1 11 00000050 00000000
12345937 80000044 1 12 12345000 00000000
00001997 80000048 1 13 80001048 00000000
00892a03 8000004c 2 14 12345008 00000001
ffc9aa83 80000050 2 15 80001044 00000000
06400b13 80000054 1 16 00000064 00000000
001b0b13 80000058 1 16 00000065 00000000
016b0bb3 8000005c 1 17 000000ca 00000000
416b8c33 80000060 1 18 00000065 00000000
017c2c83 80000064 2 19 0000007c 000000ca
00708013 80000068 1 00 0000000c 00000000
00100d33 8000006c 1 1a 00000005 00000000
00000d8b 80000070 0 1b 00000000 00000000
001d8d93 80000074 1 1b 00000001 00000000
40000e13 80000078 1 1c 00000400 00000000
011e6eb3 8000007c 1 1d 00000450 00000000
00102023 80000080 0 00 00000000 00000000
fffecf13 80000084 1 1e fffffbaf 00000000
0fff7f93 80000088 1 1f 000000af 00000000
01f030b3 8000008c 1 01 00000001 00000000
01809133 80000090 1 02 00000020 00000000
00412183 80000094 2 03 00000024 00000008

// File: bench/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk_o
);

    // 8 ns period, rising edges at 4, 12, 20 ns and so on
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #4;
        clk_o = ~clk_o;
    end

endmodule

// File: bench/tb_rv_exec.sv
`timescale 1ns/1ns

module tb_rv_exec;

    localparam int MAX_ENTRIES = 64;
    localparam int FIELDS      = 6;  // inst, pc, kind, rd, data, rs2
    localparam int KIND_NONE   = 0;
    localparam int KIND_WB     = 1;
    localparam int KIND_MEM    = 2;

    logic        clk;
    logic        rst_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic [31:0] pc_i;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic        mem_req_o;
    logic [31:0] mem_addr_o;
    logic [31:0] rs2_data_o;
    logic [31:0] pc_o;
    logic [31:0] inst_o;

    logic [31:0] trace_mem [MAX_ENTRIES*FIELDS];
    int          num_entries = 0;
    int          num_checked = 0;
    int          cycle       = 0;
    int          cycle_limit = 100000;
    int          pend_due [$];  // Cycle in which each issued instruction must show up
    integer      seed;

    tb_clkgen u_clkgen (
        .clk_o (clk)
    );

    rv_exec_top u_rv_exec_top (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .rs2_data_o   (rs2_data_o),
        .pc_o         (pc_o),
        .inst_o       (inst_o)
    );

    // ########################################################################
    // Helpers
    // ########################################################################

    function automatic logic [31:0] trace_field(input int entry, input int col);
        return trace_mem[entry*FIELDS + col];
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
            else fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    task automatic load_trace();
        for (int i = 0; i < MAX_ENTRIES*FIELDS; i++) begin
            trace_mem[i] = '0;
        end
        $readmemh("bench/rv_exec_trace.txt", trace_mem);
        // An all-zero instruction word marks the end of the trace
        while (num_entries < MAX_ENTRIES && trace_field(num_entries, 0) != '0) begin
            num_entries++;
        end
        assert (num_entries > 0) else fail_run("The trace file holds no instructions");
    endtask

    // Entries retire in issue order, so the oldest pending one is number num_checked
    task automatic check_entry(input int e);
        logic [31:0] kind;
        kind = trace_field(e, 2);
        if (kind == KIND_WB) begin
            check_value("wb_valid_o", {31'b0, wb_valid_o}, 32'd1);
            check_value("mem_req_o", {31'b0, mem_req_o}, 32'd0);
            check_value("wb_rd_o", {27'b0, wb_rd_o}, trace_field(e, 3));
            check_value("wb_data_o", wb_data_o, trace_field(e, 4));
        end else if (kind == KIND_MEM) begin
            check_value("mem_req_o", {31'b0, mem_req_o}, 32'd1);
            check_value("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
            check_value("mem_addr_o", mem_addr_o, trace_field(e, 4));
            check_value("rs2_data_o", rs2_data_o, trace_field(e, 5));
        end else begin
            check_value("wb_valid_o", {31'b0, wb_valid_o}, 32'd0);
            check_value("mem_req_o", {31'b0, mem_req_o}, 32'd0);
        end
        if (kind != KIND_NONE) begin
            check_value("pc_o", pc_o, trace_field(e, 1));
            check_value("inst_o", inst_o, trace_field(e, 0));
        end
        num_checked++;
    endtask

    // ########################################################################
    // Cycle count, timeout and output checks
    // ########################################################################

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            fail_run($sformatf("Timeout: the run did not finish within %0d cycles", cycle_limit));
        end
    end

    // Sampled at the falling edge halfway between two driving edges
    always @(negedge clk) begin
        if (!rst_i) begin
            if (inst_valid_i) begin
                pend_due.push_back(cycle + 2);  // Fixed latency of two cycles
            end
            if (pend_due.size() != 0 && pend_due[0] == cycle) begin
                pend_due.delete(0);
                check_entry(num_checked);
            end else begin
                assert (!wb_valid_o && !mem_req_o)
                    else fail_run("An output strobe arrived while no instruction was due");
            end
        end
    end

    // ########################################################################
    // Stimulus
    // ########################################################################

    initial begin
        int gap;
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        seed         = 32'hc13a;
        load_trace();
        cycle_limit = 3 * num_entries + 20;

        repeat (4) @(posedge clk);
        rst_i <= 1'b0;

        for (int i = 0; i < num_entries; i++) begin
            @(posedge clk);
            inst_valid_i <= 1'b1;
            inst_i       <= trace_field(i, 0);
            pc_i         <= trace_field(i, 1);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                inst_valid_i <= 1'b0;
            end
        end
        @(posedge clk);
        inst_valid_i <= 1'b0;

        while (pend_due.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);  // Catch any late stray strobe

        $display("Test OK");
        $finish;
    end

endmodule

// File: common/rv_isa_pkg.sv
package rv_isa_pkg;

    // ########################################################################
    // Instruction word layout
    // ########################################################################

    localparam int INST_W     = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Major opcodes handled by this slice
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOAD  = 7'b0000011,
        OP_I     = 7'b0010011,
        OP_AUIPC = 7'b0010111,
        OP_R     = 7'b0110011,
        OP_LUI   = 7'b0110111
    } opcode_e;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;  // Bit 30 picks SUB and SRA

    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

endpackage

// File: common/rv_uarch_pkg.sv
package rv_uarch_pkg;

    localparam int XLEN     = 32;
    localparam int ALU_OP_W = 4;
    localparam int SHAMT_W  = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Operations the ALU understands
    typedef enum logic [ALU_OP_W-1:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_A = 4'd10  // Used by LUI
    } alu_op_e;

endpackage

// File: exu/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  logic [rv_uarch_pkg::XLEN-1:0] a_i,
    input  logic [rv_uarch_pkg::XLEN-1:0] b_i,
    input  rv_uarch_pkg::alu_op_e         op_i,
    output logic [rv_uarch_pkg::XLEN-1:0] result_o
);

    logic [rv_uarch_pkg::SHAMT_W-1:0] shamt;
    logic                             lt_signed;
    logic                             lt_unsigned;

    assign shamt       = b_i[rv_uarch_pkg::SHAMT_W-1:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            rv_uarch_pkg::ADD:    result_o = a_i + b_i;
            rv_uarch_pkg::SUB:    result_o = a_i - b_i;
            rv_uarch_pkg::SLL:    result_o = a_i << shamt;
            rv_uarch_pkg::SLT:    result_o = {{(rv_uarch_pkg::XLEN-1){1'b0}}, lt_signed};
            rv_uarch_pkg::SLTU:   result_o = {{(rv_uarch_pkg::XLEN-1){1'b0}}, lt_unsigned};
            rv_uarch_pkg::XOR:    result_o = a_i ^ b_i;
            rv_uarch_pkg::SRL:    result_o = a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            rv_uarch_pkg::SRA:    result_o = $unsigned($signed(a_i) >>> shamt);
            rv_uarch_pkg::OR:     result_o = a_i | b_i;
            rv_uarch_pkg::AND:    result_o = a_i & b_i;
            rv_uarch_pkg::PASS_A: result_o = a_i;
            default:              result_o = a_i + b_i;
        endcase
    end

endmodule

// File: exu/rv_exu.sv
`timescale 1ns/1ns

module rv_exu (
    input  logic                              clk,
    input  logic                              rst_i,
    // From decode
    input  logic                              id_valid_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     op1_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     op2_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     pc_i,
    input  logic [rv_isa_pkg::INST_W-1:0]     inst_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                              wr_en_i,
    input  logic                              is_load_i,
    // Forwarding back to decode, also the register file write
    output logic                              ex_fwd_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     ex_fwd_data_o,
    // Registered outputs
    output logic                              wb_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     wb_data_o,
    output logic                              mem_req_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     mem_addr_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     pc_o,
    output logic [rv_isa_pkg::INST_W-1:0]     inst_o
);

    logic                              ex_valid;
    logic                              ex_wr_en;
    logic                              ex_is_load;
    logic [rv_uarch_pkg::XLEN-1:0]     ex_op1;
    logic [rv_uarch_pkg::XLEN-1:0]     ex_op2;
    logic [rv_uarch_pkg::XLEN-1:0]     ex_pc;
    logic [rv_uarch_pkg::XLEN-1:0]     ex_rs2;
    logic [rv_isa_pkg::INST_W-1:0]     ex_inst;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_rd;
    logic [rv_isa_pkg::FUNCT3_W-1:0]   funct3;
    logic [rv_isa_pkg::FUNCT7_W-1:0]   funct7;
    rv_isa_pkg::opcode_e               opcode;
    rv_uarch_pkg::alu_op_e             alu_op;
    logic [rv_uarch_pkg::XLEN-1:0]     alu_result;

    // ########################################################################
    // ID/EX registers
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid   <= 1'b0;
            ex_wr_en   <= 1'b0;
            ex_is_load <= 1'b0;
        end else begin
            ex_valid   <= id_valid_i;
            ex_wr_en   <= wr_en_i;
            ex_is_load <= is_load_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_op1  <= op1_i;
        ex_op2  <= op2_i;
        ex_pc   <= pc_i;
        ex_rs2  <= rs2_data_i;
        ex_inst <= inst_i;
        ex_rd   <= rd_addr_i;
    end

    // Control unit, works on the registered instruction
    assign opcode = rv_isa_pkg::opcode_e'(ex_inst[rv_isa_pkg::OPCODE_W-1:0]);
    assign funct3 = ex_inst[14:12];
    assign funct7 = ex_inst[31:25];

    always_comb begin
        alu_op = rv_uarch_pkg::ADD;  // AUIPC, loads and anything unknown
        case (opcode)
            rv_isa_pkg::OP_LUI: alu_op = rv_uarch_pkg::PASS_A;
            rv_isa_pkg::OP_R, rv_isa_pkg::OP_I: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD:
                        if (opcode == rv_isa_pkg::OP_R && funct7 == rv_isa_pkg::F7_ALT)
                            alu_op = rv_uarch_pkg::SUB;
                    rv_isa_pkg::F3_SLL:  alu_op = rv_uarch_pkg::SLL;
                    rv_isa_pkg::F3_SLT:  alu_op = rv_uarch_pkg::SLT;
                    rv_isa_pkg::F3_SLTU: alu_op = rv_uarch_pkg::SLTU;
                    rv_isa_pkg::F3_XOR:  alu_op = rv_uarch_pkg::XOR;
                    rv_isa_pkg::F3_SR: begin
                        if (funct7 == rv_isa_pkg::F7_BASE)
                            alu_op = rv_uarch_pkg::SRL;
                        else if (funct7 == rv_isa_pkg::F7_ALT)
                            alu_op = rv_uarch_pkg::SRA;
                    end
                    rv_isa_pkg::F3_OR:   alu_op = rv_uarch_pkg::OR;
                    rv_isa_pkg::F3_AND:  alu_op = rv_uarch_pkg::AND;
                    default:             alu_op = rv_uarch_pkg::ADD;
                endcase
            end
            default: alu_op = rv_uarch_pkg::ADD;
        endcase
    end

    rv_alu u_alu (
        .a_i      (ex_op1),
        .b_i      (ex_op2),
        .op_i     (alu_op),
        .result_o (alu_result)
    );

    assign ex_fwd_valid_o = ex_valid && ex_wr_en && (ex_rd != '0);
    assign ex_fwd_rd_o    = ex_rd;
    assign ex_fwd_data_o  = alu_result;

    // ########################################################################
    // Output registers
    // ########################################################################

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            mem_req_o  <= 1'b0;
            pc_o       <= rv_uarch_pkg::RESET_PC;
        end else begin
            wb_valid_o <= ex_valid && ex_wr_en;
            mem_req_o  <= ex_valid && ex_is_load;
            if (ex_valid)
                pc_o <= ex_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid && ex_wr_en) begin
            wb_rd_o   <= ex_rd;
            wb_data_o <= alu_result;
        end
        if (ex_valid && ex_is_load)
            mem_addr_o <= alu_result;  // Effective address
        if (ex_valid) begin
            rs2_data_o <= ex_rs2;
            inst_o     <= ex_inst;
        end
    end

    // Decode marks an instruction as writing or loading, never both
    assert property (@(posedge clk) disable iff (rst_i) !(wb_valid_o && mem_req_o))
        else $error("rv_exu: write-back and memory request raised together");

endmodule

// File: sources.f
common/rv_isa_pkg.sv
common/rv_uarch_pkg.sv
exu/rv_alu.sv
exu/rv_exu.sv
verilog/rv_regfile.sv
verilog/rv_idu.sv
verilog/rv_exec_top.sv
bench/tb_clkgen.sv
bench/tb_rv_exec.sv

// File: verilog/rv_exec_top.sv
`timescale 1ns/1ns

module rv_exec_top (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              inst_valid_i,
    input  logic [rv_isa_pkg::INST_W-1:0]     inst_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     pc_i,
    output logic                              wb_valid_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     wb_data_o,
    output logic                              mem_req_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     mem_addr_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     pc_o,
    output logic [rv_isa_pkg::INST_W-1:0]     inst_o
);

    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_uarch_pkg::XLEN-1:0]     rs1_data;
    logic [rv_uarch_pkg::XLEN-1:0]     rs2_data;
    logic                              ex_fwd_valid;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_fwd_rd;
    logic [rv_uarch_pkg::XLEN-1:0]     ex_fwd_data;
    logic                              id_valid;
    logic [rv_uarch_pkg::XLEN-1:0]     id_op1;
    logic [rv_uarch_pkg::XLEN-1:0]     id_op2;
    logic [rv_uarch_pkg::XLEN-1:0]     id_pc;
    logic [rv_isa_pkg::INST_W-1:0]     id_inst;
    logic [rv_uarch_pkg::XLEN-1:0]     id_rs2_data;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] id_rd_addr;
    logic                              id_wr_en;
    logic                              id_is_load;

    rv_idu u_idu (
        .clk            (clk),
        .rst_i          (rst_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .pc_i           (pc_i),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_fwd_valid_i (ex_fwd_valid),
        .ex_fwd_rd_i    (ex_fwd_rd),
        .ex_fwd_data_i  (ex_fwd_data),
        .id_valid_o     (id_valid),
        .op1_o          (id_op1),
        .op2_o          (id_op2),
        .pc_o           (id_pc),
        .inst_o         (id_inst),
        .rs2_data_o     (id_rs2_data),
        .rd_addr_o      (id_rd_addr),
        .wr_en_o        (id_wr_en),
        .is_load_o      (id_is_load)
    );

    // The write happens on the edge that also loads the write-back outputs
    rv_regfile u_regfile (
        .clk        (clk),
        .rst_i      (rst_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (ex_fwd_valid),
        .wr_addr_i  (ex_fwd_rd),
        .wr_data_i  (ex_fwd_data)
    );

    rv_exu u_exu (
        .clk            (clk),
        .rst_i          (rst_i),
        .id_valid_i     (id_valid),
        .op1_i          (id_op1),
        .op2_i          (id_op2),
        .pc_i           (id_pc),
        .inst_i         (id_inst),
        .rs2_data_i     (id_rs2_data),
        .rd_addr_i      (id_rd_addr),
        .wr_en_i        (id_wr_en),
        .is_load_i      (id_is_load),
        .ex_fwd_valid_o (ex_fwd_valid),
        .ex_fwd_rd_o    (ex_fwd_rd),
        .ex_fwd_data_o  (ex_fwd_data),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .rs2_data_o     (rs2_data_o),
        .pc_o           (pc_o),
        .inst_o         (inst_o)
    );

endmodule

// File: verilog/rv_idu.sv
`timescale 1ns/1ns

module rv_idu (
    input  logic                              clk,
    input  logic                              rst_i,
    // Fetch side
    input  logic                              inst_valid_i,
    input  logic [rv_isa_pkg::INST_W-1:0]     inst_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     pc_i,
    // Register file read ports
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [rv_uarch_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_i,
    // Result still sitting in execute
    input  logic                              ex_fwd_valid_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     ex_fwd_data_i,
    // To execute
    output logic                              id_valid_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     op1_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     op2_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     pc_o,
    output logic [rv_isa_pkg::INST_W-1:0]     inst_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                              wr_en_o,
    output logic                              is_load_o
);

    rv_isa_pkg::opcode_e           opcode;
    logic                          supported;
    logic [rv_uarch_pkg::XLEN-1:0] imm_i;
    logic [rv_uarch_pkg::XLEN-1:0] imm_u;
    logic [rv_uarch_pkg::XLEN-1:0] rs1_val;
    logic [rv_uarch_pkg::XLEN-1:0] rs2_val;

    assign opcode     = rv_isa_pkg::opcode_e'(inst_i[rv_isa_pkg::OPCODE_W-1:0]);
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // ########################################################################
    // Opcode classification
    // ########################################################################

    always_comb begin
        supported = 1'b1;
        wr_en_o   = 1'b0;
        is_load_o = 1'b0;
        case (opcode)
            rv_isa_pkg::OP_R,
            rv_isa_pkg::OP_I,
            rv_isa_pkg::OP_LUI,
            rv_isa_pkg::OP_AUIPC: wr_en_o   = 1'b1;
            rv_isa_pkg::OP_LOAD:  is_load_o = 1'b1;
            default:              supported = 1'b0;  // Dropped silently, no strobe
        endcase
    end

    assign id_valid_o = inst_valid_i && supported;

    // Immediates
    assign imm_i = {{(rv_uarch_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};

    // ########################################################################
    // Forwarding and operand select
    // ########################################################################

    // The forward valid already excludes x0
    assign rs1_val = (ex_fwd_valid_i && (ex_fwd_rd_i == rs1_addr_o)) ? ex_fwd_data_i
                                                                       : rs1_data_i;
    assign rs2_val = (ex_fwd_valid_i && (ex_fwd_rd_i == rs2_addr_o)) ? ex_fwd_data_i
                                                                       : rs2_data_i;

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_AUIPC: op1_o = pc_i;
            rv_isa_pkg::OP_LUI:   op1_o = imm_u;
            default:              op1_o = rs1_val;
        endcase
    end

    always_comb begin
        case (opcode)
            rv_isa_pkg::OP_R:     op2_o = rs2_val;
            rv_isa_pkg::OP_AUIPC: op2_o = imm_u;
            default:              op2_o = imm_i;  // Loads and OP-IMM
        endcase
    end

    assign pc_o       = pc_i;
    assign inst_o     = inst_i;
    assign rs2_data_o = rs2_val;

    // Upstream must present a clean word with every strobe
    assert property (@(posedge clk) disable iff (rst_i)
        inst_valid_i |-> !$isunknown(inst_i))
        else $error("rv_idu: instruction word unknown while strobed");

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [rv_uarch_pkg::XLEN-1:0]     rs1_data_o,
    output logic [rv_uarch_pkg::XLEN-1:0]     rs2_data_o,
    input  logic                              we_i,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] wr_addr_i,
    input  logic [rv_uarch_pkg::XLEN-1:0]     wr_data_i
);

    logic [rv_uarch_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is hardwired, whatever the array holds
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // Reset clears every entry, so a known index must return known data from then on
    assert property (@(posedge clk) disable iff (rst_i)
        !$isunknown({rs1_addr_i, rs2_addr_i}) |-> !$isunknown({rs1_data_o, rs2_data_o}))
        else $error("rv_regfile: unknown read data after reset");

endmodule
